//--- hw/mathCore_cfg.svh
`ifndef MATHCORE_CFG_SVH
`define MATHCORE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////////////////////////

// Data word width
`define MATH_XLEN 32

// Register file depth, register numbers are log2 of this
`define MATH_REGS 16

//////////////////////////////////////////////////////////////////////
// Multiply/divide latencies, as countdown load values
//////////////////////////////////////////////////////////////////////

`define MULT_CYCLES 5
`define DIV_CYCLES 10

`endif

//--- hw/mathPkg.sv
`include "mathCore_cfg.svh"

package mathPkg;

    // Commands offered on the issue port
    typedef enum logic [4:0] {
        cmdNop,
        cmdLdi,
        cmdAdd,
        cmdSub,
        cmdAnd,
        cmdOr,
        cmdSlt,
        cmdMult,
        cmdMultu,
        cmdDiv,
        cmdDivu,
        cmdMfhi,
        cmdMflo,
        cmdMthi,
        cmdMtlo
    } cmdOp;

    // MDU control, encoding kept from the original multiply/divide block
    typedef enum logic [3:0] {
        mduIdle  = 4'd0,
        mduMult  = 4'd1,
        mduMultu = 4'd2,
        mduDiv   = 4'd3,
        mduDivu  = 4'd4,
        mduMfhi  = 4'd5,
        mduMflo  = 4'd6,
        mduMthi  = 4'd7,
        mduMtlo  = 4'd8
    } mduCtrl;

    // Single-cycle ALU functions
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluPass
    } aluOp;

endpackage

//--- hw/mdu.sv
`include "mathCore_cfg.svh"

module mdu (
    input  logic                  clk,
    input  logic                  reset,
    input  mathPkg::mduCtrl       mduControl,
    input  logic [`MATH_XLEN-1:0] srcA,
    input  logic [`MATH_XLEN-1:0] srcB,
    output logic                  busy,
    output logic [`MATH_XLEN-1:0] hi,
    output logic [`MATH_XLEN-1:0] lo
);
    import mathPkg::*;

    // Countdown must hold the longer of the two latencies
    localparam int cntW = $clog2(`DIV_CYCLES + 1);

    logic [cntW-1:0]       count;
    logic [`MATH_XLEN-1:0] tempHi;
    logic [`MATH_XLEN-1:0] tempLo;

    logic idle;
    logic startMul;
    logic startDiv;
    logic finishing;

    //////////////////////////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////////////////////////

    assign idle      = (count == '0);
    assign startMul  = idle && ((mduControl == mduMult) || (mduControl == mduMultu));
    assign startDiv  = idle && ((mduControl == mduDiv) || (mduControl == mduDivu));
    assign finishing = (count == cntW'(1));

    //////////////////////////////////////////////////////////////////////
    // Countdown and busy flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (startMul) begin
            count <= cntW'(`MULT_CYCLES);
            busy  <= 1'b1;
        end else if (startDiv) begin
            count <= cntW'(`DIV_CYCLES);
            busy  <= 1'b1;
        end else if (finishing) begin
            count <= '0;
            busy  <= 1'b0;
        end else if (!idle) begin
            count <= count - cntW'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result temporaries
    //////////////////////////////////////////////////////////////////////

    // Computed up front, held until the countdown expires
    always_ff @(posedge clk) begin
        if (idle) begin
            case (mduControl)
                mduMult: begin
                    {tempHi, tempLo} <= $signed(srcA) * $signed(srcB);
                end
                mduMultu: begin
                    {tempHi, tempLo} <= srcA * srcB;
                end
                mduDiv: begin
                    // Truncating division, remainder takes the dividend's sign
                    tempHi <= $signed(srcA) % $signed(srcB);
                    tempLo <= $signed(srcA) / $signed(srcB);
                end
                mduDivu: begin
                    tempHi <= srcA % srcB;
                    tempLo <= srcA / srcB;
                end
                default: begin
                    tempHi <= tempHi;
                    tempLo <= tempLo;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // HI/LO
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (finishing) begin
            hi <= tempHi;
            lo <= tempLo;
        end else if (idle) begin
            // Direct moves only take effect while nothing is in flight
            if (mduControl == mduMthi) begin
                hi <= srcA;
            end
            if (mduControl == mduMtlo) begin
                lo <= srcA;
            end
        end
    end

endmodule

//--- hw/regFile.sv
`include "mathCore_cfg.svh"

module regFile (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [$clog2(`MATH_REGS)-1:0] rdAddrA,
    input  logic [$clog2(`MATH_REGS)-1:0] rdAddrB,
    input  logic                          wrEn,
    input  logic [$clog2(`MATH_REGS)-1:0] wrAddr,
    input  logic [`MATH_XLEN-1:0]         wrData,
    output logic [`MATH_XLEN-1:0]         rdDataA,
    output logic [`MATH_XLEN-1:0]         rdDataB
);

    localparam int addrW = $clog2(`MATH_REGS);

    logic [`MATH_XLEN-1:0] regs [`MATH_REGS];
    logic                  wrLive;

    // Writes to register 0 are dropped
    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MATH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Asynchronous read with same-cycle write forwarding
    function automatic logic [`MATH_XLEN-1:0] readPort(input logic [addrW-1:0] addr);
        logic [`MATH_XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wrLive && (wrAddr == addr)) begin
            value = wrData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign rdDataA = readPort(rdAddrA);
    assign rdDataB = readPort(rdAddrB);

endmodule

//--- hw/aluUnit.sv
`include "mathCore_cfg.svh"

module aluUnit (
    input  mathPkg::aluOp         op,
    input  logic [`MATH_XLEN-1:0] a,
    input  logic [`MATH_XLEN-1:0] b,
    input  logic [15:0]           imm,
    output logic [`MATH_XLEN-1:0] result
);
    import mathPkg::*;

    logic [`MATH_XLEN-1:0] immExt;
    logic                  lessThan;

    // Sign-extended immediate for load-immediate
    assign immExt = {{(`MATH_XLEN - 16){imm[15]}}, imm};

    // Signed compare
    assign lessThan = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluSlt: begin
                result = {{(`MATH_XLEN - 1){1'b0}}, lessThan};
            end
            aluPass: begin
                result = immExt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- hw/issueDecoder.sv
`include "mathCore_cfg.svh"

module issueDecoder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmdValid,
    input  mathPkg::cmdOp                 cmdOp,
    input  logic [$clog2(`MATH_REGS)-1:0] cmdRd,
    input  logic [`MATH_XLEN-1:0]         aluResult,
    input  logic [`MATH_XLEN-1:0]         hi,
    input  logic [`MATH_XLEN-1:0]         lo,
    input  logic                          mduBusy,
    output logic                          stall,
    output mathPkg::aluOp                 aluSel,
    output mathPkg::mduCtrl               mduControl,
    output logic                          wbValid,
    output logic [$clog2(`MATH_REGS)-1:0] wbAddr,
    output logic [`MATH_XLEN-1:0]         wbData
);
    import mathPkg::*;

    mduCtrl                mduMapped;
    logic                  mduClass;
    logic                  writesReg;
    logic                  accept;
    logic [`MATH_XLEN-1:0] wbNext;

    //////////////////////////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        aluSel    = aluAdd;
        mduMapped = mduIdle;
        mduClass  = 1'b0;
        writesReg = 1'b0;
        wbNext    = aluResult;
        case (cmdOp)
            cmdLdi: begin
                aluSel    = aluPass;
                writesReg = 1'b1;
            end
            cmdAdd: begin
                aluSel    = aluAdd;
                writesReg = 1'b1;
            end
            cmdSub: begin
                aluSel    = aluSub;
                writesReg = 1'b1;
            end
            cmdAnd: begin
                aluSel    = aluAnd;
                writesReg = 1'b1;
            end
            cmdOr: begin
                aluSel    = aluOr;
                writesReg = 1'b1;
            end
            cmdSlt: begin
                aluSel    = aluSlt;
                writesReg = 1'b1;
            end
            cmdMult: begin
                mduMapped = mduMult;
                mduClass  = 1'b1;
            end
            cmdMultu: begin
                mduMapped = mduMultu;
                mduClass  = 1'b1;
            end
            cmdDiv: begin
                mduMapped = mduDiv;
                mduClass  = 1'b1;
            end
            cmdDivu: begin
                mduMapped = mduDivu;
                mduClass  = 1'b1;
            end
            cmdMfhi: begin
                mduMapped = mduMfhi;
                mduClass  = 1'b1;
                writesReg = 1'b1;
                wbNext    = hi;
            end
            cmdMflo: begin
                mduMapped = mduMflo;
                mduClass  = 1'b1;
                writesReg = 1'b1;
                wbNext    = lo;
            end
            cmdMthi: begin
                mduMapped = mduMthi;
                mduClass  = 1'b1;
            end
            cmdMtlo: begin
                mduMapped = mduMtlo;
                mduClass  = 1'b1;
            end
            default: begin
                mduMapped = mduIdle;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Issue and writeback
    //////////////////////////////////////////////////////////////////////

    // Only MDU-class commands wait on the multiply/divide unit
    assign stall  = cmdValid && mduClass && mduBusy;
    assign accept = cmdValid && !stall;

    // Held commands must not restart the MDU
    assign mduControl = accept ? mduMapped : mduIdle;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= accept && writesReg;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && writesReg) begin
            wbAddr <= cmdRd;
            wbData <= wbNext;
        end
    end

endmodule

//--- hw/mathCore.sv
`include "mathCore_cfg.svh"

module mathCore (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmdValid,
    input  mathPkg::cmdOp                 cmdOp,
    input  logic [$clog2(`MATH_REGS)-1:0] cmdRs,
    input  logic [$clog2(`MATH_REGS)-1:0] cmdRt,
    input  logic [$clog2(`MATH_REGS)-1:0] cmdRd,
    input  logic [15:0]                   cmdImm,
    output logic                          stall,
    output logic                          wbValid,
    output logic [$clog2(`MATH_REGS)-1:0] wbAddr,
    output logic [`MATH_XLEN-1:0]         wbData
);
    import mathPkg::*;

    aluOp                  aluSel;
    mduCtrl                mduControl;
    logic [`MATH_XLEN-1:0] rdDataA;
    logic [`MATH_XLEN-1:0] rdDataB;
    logic [`MATH_XLEN-1:0] aluResult;
    logic [`MATH_XLEN-1:0] hi;
    logic [`MATH_XLEN-1:0] lo;
    logic                  mduBusy;

    //////////////////////////////////////////////////////////////////////
    // Issue control
    //////////////////////////////////////////////////////////////////////

    issueDecoder issueDecoder_inst (
        .clk        (clk),
        .reset      (reset),
        .cmdValid   (cmdValid),
        .cmdOp      (cmdOp),
        .cmdRd      (cmdRd),
        .aluResult  (aluResult),
        .hi         (hi),
        .lo         (lo),
        .mduBusy    (mduBusy),
        .stall      (stall),
        .aluSel     (aluSel),
        .mduControl (mduControl),
        .wbValid    (wbValid),
        .wbAddr     (wbAddr),
        .wbData     (wbData)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    // Registered writeback doubles as the register write port
    regFile regFile_inst (
        .clk     (clk),
        .reset   (reset),
        .rdAddrA (cmdRs),
        .rdAddrB (cmdRt),
        .wrEn    (wbValid),
        .wrAddr  (wbAddr),
        .wrData  (wbData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    aluUnit aluUnit_inst (
        .op     (aluSel),
        .a      (rdDataA),
        .b      (rdDataB),
        .imm    (cmdImm),
        .result (aluResult)
    );

    mdu mdu_inst (
        .clk        (clk),
        .reset      (reset),
        .mduControl (mduControl),
        .srcA       (rdDataA),
        .srcB       (rdDataB),
        .busy       (mduBusy),
        .hi         (hi),
        .lo         (lo)
    );

endmodule

//--- sim/mathCore_assertions.sv
`include "mathCore_cfg.svh"

module mathCore_assertions (
    input logic                          clk,
    input logic                          reset,
    input logic                          cmdValid,
    input mathPkg::cmdOp                 cmdOp,
    input logic [$clog2(`MATH_REGS)-1:0] cmdRs,
    input logic [$clog2(`MATH_REGS)-1:0] cmdRt,
    input logic [$clog2(`MATH_REGS)-1:0] cmdRd,
    input logic [15:0]                   cmdImm,
    input logic                          stall,
    input logic                          wbValid,
    input logic [$clog2(`MATH_REGS)-1:0] wbAddr,
    input logic [`MATH_XLEN-1:0]         wbData
);
    import mathPkg::*;

    logic [`MATH_XLEN-1:0]         shadowRegs [`MATH_REGS];
    logic [`MATH_XLEN-1:0]         shadowHi;
    logic [`MATH_XLEN-1:0]         shadowLo;
    logic [`MATH_XLEN-1:0]         pendHi;
    logic [`MATH_XLEN-1:0]         pendLo;
    logic [`MATH_XLEN-1:0]         rsVal;
    logic [`MATH_XLEN-1:0]         rtVal;
    logic [`MATH_XLEN-1:0]         result;
    logic [$clog2(`MATH_REGS)-1:0] expAddr;
    logic [`MATH_XLEN-1:0]         expData;
    logic                          expValid;
    logic                          writes;
    logic                          mduCmd;
    logic                          expStall;
    logic                          accepted;
    int                            shadowCount;
    int                            errorCount = 0;

    // Truncating signed division built from magnitudes
    // Remainder packed above the quotient
    function automatic logic [63:0] divideSigned(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] magA;
        logic [31:0] magB;
        logic [31:0] quot;
        logic [31:0] rem;
        magA = a[31] ? -a : a;
        magB = b[31] ? -b : b;
        quot = magA / magB;
        rem  = magA % magB;
        return {(a[31] ? -rem : rem), ((a[31] ^ b[31]) ? -quot : quot)};
    endfunction

    assign rsVal    = shadowRegs[cmdRs];
    assign rtVal    = shadowRegs[cmdRt];
    assign mduCmd   = cmdOp inside {cmdMult, cmdMultu, cmdDiv, cmdDivu,
                                    cmdMfhi, cmdMflo, cmdMthi, cmdMtlo};
    assign expStall = cmdValid && mduCmd && (shadowCount != 0);
    assign accepted = cmdValid && !expStall;

    always_comb begin
        writes = 1'b1;
        case (cmdOp)
            cmdLdi:  result = {{16{cmdImm[15]}}, cmdImm};
            cmdAdd:  result = rsVal + rtVal;
            cmdSub:  result = rsVal - rtVal;
            cmdAnd:  result = rsVal & rtVal;
            cmdOr:   result = rsVal | rtVal;
            cmdSlt:  result = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
            cmdMfhi: result = shadowHi;
            cmdMflo: result = shadowLo;
            default: begin
                writes = 1'b0;
                result = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Shadow model
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MATH_REGS; i++) begin
                shadowRegs[i] <= '0;
            end
            shadowHi    <= '0;
            shadowLo    <= '0;
            shadowCount <= 0;
            expValid    <= 1'b0;
        end else begin
            expValid <= accepted && writes;
            if (shadowCount == 1) begin
                shadowHi <= pendHi;
                shadowLo <= pendLo;
            end
            if (shadowCount != 0) begin
                shadowCount <= shadowCount - 1;
            end
            if (accepted && writes) begin
                expAddr <= cmdRd;
                expData <= result;
                // Register 0 stays zero
                if (cmdRd != '0) begin
                    shadowRegs[cmdRd] <= result;
                end
            end
            if (accepted) begin
                case (cmdOp)
                    cmdMult: begin
                        {pendHi, pendLo} <= {{32{rsVal[31]}}, rsVal} * {{32{rtVal[31]}}, rtVal};
                        shadowCount <= `MULT_CYCLES;
                    end
                    cmdMultu: begin
                        {pendHi, pendLo} <= {32'd0, rsVal} * {32'd0, rtVal};
                        shadowCount <= `MULT_CYCLES;
                    end
                    cmdDiv: begin
                        {pendHi, pendLo} <= divideSigned(rsVal, rtVal);
                        shadowCount <= `DIV_CYCLES;
                    end
                    cmdDivu: begin
                        pendHi <= rsVal % rtVal;
                        pendLo <= rsVal / rtVal;
                        shadowCount <= `DIV_CYCLES;
                    end
                    cmdMthi: shadowHi <= rsVal;
                    cmdMtlo: shadowLo <= rsVal;
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    wbValidCheck: assert property (@(posedge clk) disable iff (reset)
        wbValid == expValid)
        else begin
            errorCount++;
            $error("** Error wbValid expected %h actual %h",
                   $sampled(expValid), $sampled(wbValid));
        end

    wbAddrCheck: assert property (@(posedge clk) disable iff (reset)
        wbValid |-> wbAddr == expAddr)
        else begin
            errorCount++;
            $error("** Error wbAddr expected %h actual %h",
                   $sampled(expAddr), $sampled(wbAddr));
        end

    wbDataCheck: assert property (@(posedge clk) disable iff (reset)
        wbValid |-> wbData == expData)
        else begin
            errorCount++;
            $error("** Error wbData expected %h actual %h",
                   $sampled(expData), $sampled(wbData));
        end

    stallCheck: assert property (@(posedge clk) disable iff (reset)
        stall == expStall)
        else begin
            errorCount++;
            $error("** Error stall expected %h actual %h",
                   $sampled(expStall), $sampled(stall));
        end

endmodule

//--- sim/mathCore_tb.sv
`include "mathCore_cfg.svh"

module mathCore_tb;
    import mathPkg::*;

    localparam int halfPeriod    = 20;
    localparam int totalCommands = 250;

    logic                          clk;
    logic                          reset;
    logic                          cmdValid;
    mathPkg::cmdOp                 opCode;
    logic [$clog2(`MATH_REGS)-1:0] cmdRs;
    logic [$clog2(`MATH_REGS)-1:0] cmdRt;
    logic [$clog2(`MATH_REGS)-1:0] cmdRd;
    logic [15:0]                   cmdImm;
    logic                          stall;
    logic                          wbValid;
    logic [$clog2(`MATH_REGS)-1:0] wbAddr;
    logic [`MATH_XLEN-1:0]         wbData;

    int commandsSent = 0;
    int stallsSeen   = 0;
    int testsRun     = 0;
    int failures;

    mathCore mathCore_inst (
        .clk      (clk),
        .reset    (reset),
        .cmdValid (cmdValid),
        .cmdOp    (opCode),
        .cmdRs    (cmdRs),
        .cmdRt    (cmdRt),
        .cmdRd    (cmdRd),
        .cmdImm   (cmdImm),
        .stall    (stall),
        .wbValid  (wbValid),
        .wbAddr   (wbAddr),
        .wbData   (wbData)
    );

    bind mathCore mathCore_assertions coreChecks (.*);

    always #halfPeriod clk = ~clk;

    // Starts at a falling edge, holds the command until it is taken
    task automatic issue(input cmdOp op, input int rs, input int rt, input int rd,
                         input logic [15:0] imm);
        logic taken;
        cmdValid = 1'b1;
        opCode   = op;
        cmdRs    = rs;
        cmdRt    = rt;
        cmdRd    = rd;
        cmdImm   = imm;
        taken    = 1'b0;
        while (!taken) begin
            // Mid low phase, stall has settled
            #(halfPeriod / 2);
            taken = !stall;
            if (stall) begin
                stallsSeen++;
            end
            @(negedge clk);
        end
        cmdValid = 1'b0;
        opCode   = cmdNop;
        commandsSent++;
    endtask

    task automatic reportTest(input string name);
        repeat (2) @(negedge clk);
        testsRun++;
        $display("%s finished: %0d commands, %0d stalls, %0d assertion failures so far",
                 name, commandsSent, stallsSeen, mathCore_inst.coreChecks.errorCount);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Directed and random tests
    ////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hef359e48));
        clk      = 1'b0;
        reset    = 1'b1;
        cmdValid = 1'b0;
        opCode   = cmdNop;
        cmdRs    = '0;
        cmdRt    = '0;
        cmdRd    = '0;
        cmdImm   = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // ALU with dependent back-to-back commands and register 0
        issue(cmdLdi, 0, 0, 1, 16'd5);
        issue(cmdLdi, 0, 0, 2, 16'hfffd);
        issue(cmdAdd, 1, 2, 3, 16'd0);
        issue(cmdSub, 3, 1, 4, 16'd0);
        issue(cmdAnd, 2, 1, 5, 16'd0);
        issue(cmdOr, 4, 2, 6, 16'd0);
        issue(cmdSlt, 2, 1, 7, 16'd0);
        issue(cmdLdi, 0, 0, 0, 16'h1234);
        issue(cmdAdd, 0, 1, 8, 16'd0);
        reportTest("alu");

        issue(cmdLdi, 0, 0, 1, 16'hfff9);
        issue(cmdLdi, 0, 0, 2, 16'h7abc);
        issue(cmdMult, 1, 2, 0, 16'd0);
        issue(cmdMfhi, 0, 0, 3, 16'd0);
        issue(cmdMflo, 0, 0, 4, 16'd0);
        issue(cmdMultu, 1, 2, 0, 16'd0);
        issue(cmdMfhi, 0, 0, 5, 16'd0);
        issue(cmdMflo, 0, 0, 6, 16'd0);
        reportTest("multiply");

        issue(cmdLdi, 0, 0, 1, 16'hff9c);
        issue(cmdLdi, 0, 0, 2, 16'd7);
        issue(cmdDiv, 1, 2, 0, 16'd0);
        issue(cmdMfhi, 0, 0, 3, 16'd0);
        issue(cmdMflo, 0, 0, 4, 16'd0);
        issue(cmdDivu, 1, 2, 0, 16'd0);
        issue(cmdMfhi, 0, 0, 5, 16'd0);
        issue(cmdMflo, 0, 0, 6, 16'd0);
        reportTest("divide");

        issue(cmdLdi, 0, 0, 9, 16'h8001);
        issue(cmdMthi, 9, 0, 0, 16'd0);
        issue(cmdLdi, 0, 0, 10, 16'h0246);
        issue(cmdMtlo, 10, 0, 0, 16'd0);
        issue(cmdMfhi, 0, 0, 11, 16'd0);
        issue(cmdMflo, 0, 0, 12, 16'd0);
        reportTest("move");

        // ALU work flows past a busy MDU, MDU commands wait
        issue(cmdDiv, 9, 10, 0, 16'd0);
        issue(cmdAdd, 9, 10, 13, 16'd0);
        issue(cmdOr, 13, 9, 14, 16'd0);
        issue(cmdMthi, 14, 0, 0, 16'd0);
        issue(cmdMult, 13, 14, 0, 16'd0);
        issue(cmdMflo, 0, 0, 1, 16'd0);
        reportTest("stall");

        // Register 15 is the divisor for every random divide
        issue(cmdLdi, 0, 0, 15, 16'($urandom_range(16'hffff, 1)));
        for (int i = 0; i < 200; i++) begin
            cmdOp op;
            op = cmdOp'($urandom_range(14, 0));
            if (op == cmdDiv || op == cmdDivu) begin
                issue(op, $urandom_range(15, 0), 15, 0, 16'd0);
            end else begin
                issue(op, $urandom_range(15, 0), $urandom_range(15, 0),
                      $urandom_range(14, 0), 16'($urandom()));
            end
        end
        reportTest("random");

        failures = mathCore_inst.coreChecks.errorCount;
        $display("Tests %0d, commands %0d, stalls %0d, assertion failures %0d",
                 testsRun, commandsSent, stallsSeen, failures);
        if (failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Worst case every command waits out a full divide
    initial begin
        #((10 + totalCommands * (`DIV_CYCLES + 4)) * 2 * halfPeriod);
        $display("Timeout: the tests did not complete in the expected number of cycles");
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+hw
hw/mathPkg.sv
hw/mdu.sv
hw/regFile.sv
hw/aluUnit.sv
hw/issueDecoder.sv
hw/mathCore.sv
sim/mathCore_assertions.sv
sim/mathCore_tb.sv
